// File: mem_pkg.sv
package mem_pkg;

	// ----------------------------------------
	// vector types
	// ----------------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [2:0]  size_t;  // axi beat size, log2 of bytes

	// risc-v load/store funct3
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;
	localparam funct3_t F3_SB  = 3'b000;
	localparam funct3_t F3_SH  = 3'b001;
	localparam funct3_t F3_SW  = 3'b010;

	// ----------------------------------------
	// icache geometry
	// ----------------------------------------
	localparam int IC_LINES    = 8;
	localparam int IC_WORDS    = 4;
	localparam int IC_INDEX_W  = 3;
	localparam int IC_OFFSET_W = 4;  // byte offset in a line
	localparam int IC_TAG_W    = 32 - IC_INDEX_W - IC_OFFSET_W;

	// address map
	localparam addr_t CLINT_BASE      = 32'h0200_0000;
	localparam addr_t CLINT_SPAN_MASK = 32'hFFFF_0000;
	localparam addr_t MTIME_HI_OFF    = 32'h0000_0004;

endpackage

// File: icache.sv
module icache (
	input  logic           clock,
	input  logic           reset,
	input  logic           fetch_req,
	input  mem_pkg::addr_t fetch_addr,
	output logic           fetch_ack,
	output mem_pkg::data_t fetch_inst,
	input  logic           fence_i,
	output logic           ic_arvalid,
	input  logic           ic_arready,
	output mem_pkg::addr_t ic_araddr,
	output logic [7:0]     ic_arlen,
	input  logic           ic_rvalid,
	output logic           ic_rready,
	input  mem_pkg::data_t ic_rdata,
	input  logic           ic_rlast
);
	import mem_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_REFILL,
		S_RESPOND,
		S_RELEASE
	} state_t;

	state_t state;
	addr_t req_addr;
	logic [IC_LINES-1:0] valid;
	logic [IC_TAG_W-1:0] tags [IC_LINES];
	data_t lines [IC_LINES*IC_WORDS];
	logic [IC_OFFSET_W-3:0] beat;  // refill word counter

	logic [IC_INDEX_W-1:0] index;
	logic [IC_TAG_W-1:0] tag;
	logic [IC_OFFSET_W-3:0] word;
	logic hit;
	logic r_fire;

	assign index = req_addr[IC_OFFSET_W +: IC_INDEX_W];
	assign tag = req_addr[31 -: IC_TAG_W];
	assign word = req_addr[IC_OFFSET_W-1:2];
	assign hit = valid[index] && (tags[index] == tag);

	assign ic_araddr = {req_addr[31:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}};
	assign ic_arlen = 8'(IC_WORDS - 1);
	assign ic_rready = (state == S_REFILL) && !ic_arvalid;
	assign r_fire = ic_rvalid && ic_rready;

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			fetch_ack <= 1'b0;
			ic_arvalid <= 1'b0;
			valid <= '0;
			beat <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (fence_i)
						valid <= '0;
					if (fetch_req)
						state <= S_LOOKUP;
				end
				S_LOOKUP: begin
					if (hit) begin
						fetch_ack <= 1'b1;
						state <= S_RESPOND;
					end else begin
						ic_arvalid <= 1'b1;  // one burst per line
						beat <= '0;
						state <= S_REFILL;
					end
				end
				S_REFILL: begin
					if (ic_arvalid && ic_arready)
						ic_arvalid <= 1'b0;
					if (r_fire) begin
						beat <= beat + 1'b1;
						if (ic_rlast) begin
							valid[index] <= 1'b1;
							fetch_ack <= 1'b1;
							state <= S_RESPOND;
						end
					end
				end
				S_RESPOND: begin
					if (!fetch_req) begin  // four-phase return
						fetch_ack <= 1'b0;
						state <= S_RELEASE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// arrays and payload
	always_ff @(posedge clock) begin
		if (state == S_IDLE && fetch_req)
			req_addr <= fetch_addr;
		if (state == S_LOOKUP && hit)
			fetch_inst <= lines[{index, word}];
		if (r_fire) begin
			lines[{index, beat}] <= ic_rdata;
			if (beat == word)
				fetch_inst <= ic_rdata;  // critical word straight out
			if (ic_rlast)
				tags[index] <= tag;
		end
	end

endmodule

// File: lsu.sv
module lsu (
	input  logic             clock,
	input  logic             reset,
	input  logic             mem_req,
	input  logic             mem_we,
	input  mem_pkg::funct3_t mem_funct3,
	input  mem_pkg::addr_t   mem_addr,
	input  mem_pkg::data_t   mem_wdata,
	output logic             mem_ack,
	output mem_pkg::data_t   mem_rdata,
	output logic             ls_arvalid,
	input  logic             ls_arready,
	output mem_pkg::addr_t   ls_araddr,
	output mem_pkg::size_t   ls_arsize,
	input  logic             ls_rvalid,
	output logic             ls_rready,
	input  mem_pkg::data_t   ls_rdata,
	output logic             ls_awvalid,
	input  logic             ls_awready,
	output mem_pkg::addr_t   ls_awaddr,
	output mem_pkg::size_t   ls_awsize,
	output logic             ls_wvalid,
	input  logic             ls_wready,
	output mem_pkg::data_t   ls_wdata,
	output mem_pkg::strb_t   ls_wstrb,
	input  logic             ls_bvalid,
	output logic             ls_bready
);
	import mem_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE, S_DONE} state_t;

	state_t state;
	funct3_t f3_q;
	addr_t addr_q;
	size_t size_q;
	strb_t strb_next;
	data_t shifted;
	data_t load_val;

	assign ls_araddr = addr_q;
	assign ls_awaddr = addr_q;
	assign ls_arsize = size_q;
	assign ls_awsize = size_q;
	assign ls_rready = (state == S_READ) && !ls_arvalid;
	assign ls_bready = (state == S_WRITE);

	always_comb begin
		case (mem_funct3)
			F3_SB: strb_next = strb_t'(4'b0001 << mem_addr[1:0]);
			F3_SH: strb_next = strb_t'(4'b0011 << mem_addr[1:0]);
			F3_SW: strb_next = 4'b1111;
			default: strb_next = 4'b1111;
		endcase
	end

	// lane extract and extend
	assign shifted = ls_rdata >> {addr_q[1:0], 3'b000};
	always_comb begin
		case (f3_q)
			F3_LB: load_val = {{24{shifted[7]}}, shifted[7:0]};
			F3_LH: load_val = {{16{shifted[15]}}, shifted[15:0]};
			F3_LBU: load_val = {24'b0, shifted[7:0]};
			F3_LHU: load_val = {16'b0, shifted[15:0]};
			F3_LW: load_val = shifted;
			default: load_val = shifted;
		endcase
	end

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			mem_ack <= 1'b0;
			ls_arvalid <= 1'b0;
			ls_awvalid <= 1'b0;
			ls_wvalid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (mem_req && mem_we) begin
						ls_awvalid <= 1'b1;
						ls_wvalid <= 1'b1;
						state <= S_WRITE;
					end else if (mem_req) begin
						ls_arvalid <= 1'b1;
						state <= S_READ;
					end
				end
				S_READ: begin
					if (ls_arvalid && ls_arready)
						ls_arvalid <= 1'b0;
					if (ls_rvalid && ls_rready) begin
						mem_ack <= 1'b1;
						state <= S_DONE;
					end
				end
				S_WRITE: begin
					if (ls_awvalid && ls_awready)
						ls_awvalid <= 1'b0;
					if (ls_wvalid && ls_wready)
						ls_wvalid <= 1'b0;
					if (ls_bvalid && ls_bready) begin
						mem_ack <= 1'b1;
						state <= S_DONE;
					end
				end
				default: begin
					if (!mem_req) begin
						mem_ack <= 1'b0;
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_IDLE && mem_req) begin
			f3_q <= mem_funct3;
			addr_q <= mem_addr;
			size_q <= {1'b0, mem_funct3[1:0]};
			ls_wdata <= mem_wdata << {mem_addr[1:0], 3'b000};  // onto byte lanes
			ls_wstrb <= strb_next;
		end
		if (ls_rvalid && ls_rready)
			mem_rdata <= load_val;
	end

endmodule

// File: xbar.sv
module xbar (
	input  logic           clock,
	input  logic           reset,
	// cache refill
	input  logic           ic_arvalid,
	output logic           ic_arready,
	input  mem_pkg::addr_t ic_araddr,
	input  logic [7:0]     ic_arlen,
	output logic           ic_rvalid,
	input  logic           ic_rready,
	output mem_pkg::data_t ic_rdata,
	output logic           ic_rlast,
	// lsu
	input  logic           ls_arvalid,
	output logic           ls_arready,
	input  mem_pkg::addr_t ls_araddr,
	input  mem_pkg::size_t ls_arsize,
	output logic           ls_rvalid,
	input  logic           ls_rready,
	output mem_pkg::data_t ls_rdata,
	input  logic           ls_awvalid,
	output logic           ls_awready,
	input  mem_pkg::addr_t ls_awaddr,
	input  mem_pkg::size_t ls_awsize,
	input  logic           ls_wvalid,
	output logic           ls_wready,
	input  mem_pkg::data_t ls_wdata,
	input  mem_pkg::strb_t ls_wstrb,
	output logic           ls_bvalid,
	input  logic           ls_bready,
	// timer
	output logic           clint_arvalid,
	input  logic           clint_arready,
	output mem_pkg::addr_t clint_araddr,
	input  logic           clint_rvalid,
	output logic           clint_rready,
	input  mem_pkg::data_t clint_rdata,
	// external bus
	output logic           awvalid,
	input  logic           awready,
	output mem_pkg::addr_t awaddr,
	output mem_pkg::size_t awsize,
	output logic           wvalid,
	input  logic           wready,
	output mem_pkg::data_t wdata,
	output mem_pkg::strb_t wstrb,
	output logic           wlast,
	input  logic           bvalid,
	output logic           bready,
	input  logic [1:0]     bresp,
	output logic           arvalid,
	input  logic           arready,
	output mem_pkg::addr_t araddr,
	output logic [7:0]     arlen,
	output mem_pkg::size_t arsize,
	output logic [1:0]     arburst,
	input  logic           rvalid,
	output logic           rready,
	input  mem_pkg::data_t rdata,
	input  logic [1:0]     rresp,
	input  logic           rlast
);
	import mem_pkg::*;

	typedef enum logic [1:0] {OWN_FREE, OWN_CACHE, OWN_LSU} owner_t;

	owner_t owner;
	logic rd_clint;          // open read sits on the timer
	logic pend, pend_lsu;    // grant held while ar waits for ready
	logic req_any, grant_lsu, sel_clint, sel_ready, ar_fire;
	addr_t sel_addr;
	logic src_rvalid, src_rlast, dst_rready, r_fire;
	data_t src_rdata;
	logic w_clint, b_local;

	// ----------------------------------------
	// read address
	// ----------------------------------------
	assign req_any = (owner == OWN_FREE) && (ic_arvalid || ls_arvalid);
	assign grant_lsu = pend ? pend_lsu : ls_arvalid;  // lsu first
	assign sel_addr = grant_lsu ? ls_araddr : ic_araddr;
	assign sel_clint = (sel_addr & CLINT_SPAN_MASK) == CLINT_BASE;
	assign sel_ready = sel_clint ? clint_arready : arready;
	assign ar_fire = req_any && sel_ready;

	assign arvalid = req_any && !sel_clint;
	assign araddr = sel_addr;
	assign arlen = grant_lsu ? 8'd0 : ic_arlen;
	assign arsize = grant_lsu ? ls_arsize : size_t'(3'd2);
	assign arburst = 2'b01;  // INCR
	assign clint_arvalid = req_any && sel_clint;
	assign clint_araddr = sel_addr;
	assign ic_arready = req_any && !grant_lsu && sel_ready;
	assign ls_arready = req_any && grant_lsu && sel_ready;

	// read data back to the owner
	assign src_rvalid = rd_clint ? clint_rvalid : rvalid;
	assign src_rdata = rd_clint ? clint_rdata : rdata;
	assign src_rlast = rd_clint || rlast;  // timer is single beat
	assign dst_rready = ((owner == OWN_CACHE) && ic_rready) || ((owner == OWN_LSU) && ls_rready);
	assign rready = !rd_clint && dst_rready;
	assign clint_rready = rd_clint && dst_rready;
	assign ic_rvalid = (owner == OWN_CACHE) && src_rvalid;
	assign ls_rvalid = (owner == OWN_LSU) && src_rvalid;
	assign ic_rdata = src_rdata;
	assign ls_rdata = src_rdata;
	assign ic_rlast = src_rlast;
	assign r_fire = src_rvalid && dst_rready;

	// ----------------------------------------
	// writes
	// ----------------------------------------
	assign w_clint = (ls_awaddr & CLINT_SPAN_MASK) == CLINT_BASE;
	assign awvalid = ls_awvalid && !w_clint;
	assign awaddr = ls_awaddr;
	assign awsize = ls_awsize;
	assign wvalid = ls_wvalid && !w_clint;
	assign wdata = ls_wdata;
	assign wstrb = ls_wstrb;
	assign wlast = 1'b1;
	assign ls_awready = ls_awvalid && (w_clint || awready);
	assign ls_wready = ls_wvalid && (w_clint || wready);
	assign bready = ls_bready && !w_clint;
	assign ls_bvalid = b_local || (bvalid && !w_clint);

	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= OWN_FREE;
			rd_clint <= 1'b0;
			pend <= 1'b0;
			pend_lsu <= 1'b0;
			b_local <= 1'b0;
		end else begin
			case (owner)
				OWN_FREE: begin
					if (ar_fire) begin
						if (grant_lsu)
							owner <= OWN_LSU;
						else
							owner <= OWN_CACHE;
						rd_clint <= sel_clint;
						pend <= 1'b0;
					end else if (req_any) begin
						pend <= 1'b1;
						pend_lsu <= grant_lsu;
					end
				end
				default: begin
					if (r_fire && src_rlast)
						owner <= OWN_FREE;
				end
			endcase

			// timer stores end here
			if (ls_bvalid && ls_bready)
				b_local <= 1'b0;
			else if (w_clint && ls_wvalid)
				b_local <= 1'b1;
		end
	end

endmodule

// File: clint.sv
module clint (
	input  logic           clock,
	input  logic           reset,
	input  logic           clint_arvalid,
	output logic           clint_arready,
	input  mem_pkg::addr_t clint_araddr,
	output logic           clint_rvalid,
	input  logic           clint_rready,
	output mem_pkg::data_t clint_rdata
);
	import mem_pkg::*;

	logic [63:0] mtime;
	logic sel_hi;

	assign clint_arready = 1'b1;
	assign sel_hi = clint_araddr[3:2] == MTIME_HI_OFF[3:2];

	// ----------------------------------------
	// machine time
	// ----------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
			clint_rvalid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (clint_arvalid)
				clint_rvalid <= 1'b1;
			else if (clint_rvalid && clint_rready)
				clint_rvalid <= 1'b0;
		end
	end

	// word snapshot at the address beat
	always_ff @(posedge clock) begin
		if (clint_arvalid) begin
			if (sel_hi)
				clint_rdata <= mtime[63:32];
			else
				clint_rdata <= mtime[31:0];
		end
	end

endmodule

// File: mem_subsys.sv
module mem_subsys (
	input  logic             clock,
	input  logic             reset,
	// fetch port
	input  logic             fetch_req,
	input  mem_pkg::addr_t   fetch_addr,
	output logic             fetch_ack,
	output mem_pkg::data_t   fetch_inst,
	input  logic             fence_i,
	// data port
	input  logic             mem_req,
	input  logic             mem_we,
	input  mem_pkg::funct3_t mem_funct3,
	input  mem_pkg::addr_t   mem_addr,
	input  mem_pkg::data_t   mem_wdata,
	output logic             mem_ack,
	output mem_pkg::data_t   mem_rdata,
	// external bus
	output logic             awvalid,
	input  logic             awready,
	output mem_pkg::addr_t   awaddr,
	output mem_pkg::size_t   awsize,
	output logic             wvalid,
	input  logic             wready,
	output mem_pkg::data_t   wdata,
	output mem_pkg::strb_t   wstrb,
	output logic             wlast,
	input  logic             bvalid,
	output logic             bready,
	input  logic [1:0]       bresp,
	output logic             arvalid,
	input  logic             arready,
	output mem_pkg::addr_t   araddr,
	output logic [7:0]       arlen,
	output mem_pkg::size_t   arsize,
	output logic [1:0]       arburst,
	input  logic             rvalid,
	output logic             rready,
	input  mem_pkg::data_t   rdata,
	input  logic [1:0]       rresp,
	input  logic             rlast
);
	import mem_pkg::*;

	// ----------------------------------------
	// internal channels
	// ----------------------------------------
	logic ic_arvalid, ic_arready, ic_rvalid, ic_rready, ic_rlast;
	addr_t ic_araddr;
	logic [7:0] ic_arlen;
	data_t ic_rdata;

	logic ls_arvalid, ls_arready, ls_rvalid, ls_rready;
	logic ls_awvalid, ls_awready, ls_wvalid, ls_wready, ls_bvalid, ls_bready;
	addr_t ls_araddr, ls_awaddr;
	size_t ls_arsize, ls_awsize;
	data_t ls_rdata, ls_wdata;
	strb_t ls_wstrb;

	logic clint_arvalid, clint_arready, clint_rvalid, clint_rready;
	addr_t clint_araddr;
	data_t clint_rdata;

	icache icache_i (.*);

	lsu lsu_i (.*);

	xbar xbar_i (.*);  // reads merged here

	clint clint_i (.*);

endmodule

// File: mem_subsys_assert.sv
module mem_subsys_assert (
	input logic           clock,
	input logic           reset,
	input logic           fetch_req,
	input logic           fetch_ack,
	input logic           mem_req,
	input logic           mem_ack,
	input logic           arvalid,
	input logic           arready,
	input mem_pkg::addr_t araddr,
	input logic [7:0]     arlen,
	input logic           awvalid,
	input logic           awready,
	input mem_pkg::addr_t awaddr,
	input logic           wvalid,
	input logic           wready,
	input mem_pkg::data_t wdata,
	input mem_pkg::strb_t wstrb
);
	timeunit 1ns;
	timeprecision 100ps;

	// ----------------------------------------
	// bus stability under back-pressure
	// ----------------------------------------
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("ar dropped or changed before ready");
	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("aw dropped or changed before ready");
	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("w dropped or changed before ready");

	ack_reset: assert property (@(posedge clock) reset |=> !fetch_ack && !mem_ack)
		else $error("ack high after reset");

	// four-phase ports
	fetch_order: assert property (@(posedge clock) disable iff (reset)
		$rose(fetch_req) |-> !fetch_ack)
		else $error("fetch req raised while ack high");
	mem_order: assert property (@(posedge clock) disable iff (reset)
		$rose(mem_req) |-> !mem_ack)
		else $error("mem req raised while ack high");

endmodule

bind mem_subsys mem_subsys_assert mem_subsys_assert_i (.*);

// File: tb_mem_subsys.sv
module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_pkg::*;

	typedef enum {FETCH, FENCE, LOAD, STORE, TIMER, BOTH} port_t;
	typedef struct {
		port_t port;
		addr_t addr;
		addr_t addr2;     // load address of a contention row
		funct3_t f3;
		data_t wdata;
		data_t exp_val;
		data_t exp_val2;
		strb_t exp_strb;
		size_t exp_size;
		logic [7:0] exp_len;
		int ar_new;
		int aw_new;
	} row_t;

	logic clock, reset;
	logic fetch_req, fence_i, fetch_ack;
	addr_t fetch_addr;
	data_t fetch_inst;
	logic mem_req, mem_we, mem_ack;
	funct3_t mem_funct3;
	addr_t mem_addr;
	data_t mem_wdata, mem_rdata;
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	addr_t awaddr, araddr;
	size_t awsize, arsize;
	data_t wdata, rdata;
	strb_t wstrb;
	logic [1:0] bresp, arburst, rresp;
	logic arvalid, arready, rvalid, rready, rlast;
	logic [7:0] arlen;

	row_t rows [40];
	int n_rows = 0;
	int errors = 0;
	logic table_ready = 1'b0;
	data_t golden [1024];

	mem_subsys mem_subsys_i (.*);

	always #4 clock = ~clock;

	// ----------------------------------------
	// external memory model
	// ----------------------------------------
	data_t mem [1024];
	logic [31:0] lcg_state = 32'd39833;
	logic rd_active, aw_done, w_done;
	addr_t rd_addr;
	int rd_left, ar_wait, r_wait, wr_wait;
	int ar_count = 0;
	int aw_count = 0;
	strb_t last_wstrb;
	logic [7:0] last_arlen;
	size_t last_arsize, last_awsize;
	logic [1:0] last_arburst;
	logic last_wlast;
	logic ar_f, r_f, aw_f, w_f, b_f;

	function automatic data_t init_word(int idx);
		return data_t'(idx) * 32'h0101_0101 + 32'h1357;
	endfunction

	function int next_delay();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[20:16]) % 3;
	endfunction

	always begin
		@(negedge clock);
		ar_f = arvalid && arready;
		r_f = rvalid && rready;
		aw_f = awvalid && awready;
		w_f = wvalid && wready;
		b_f = bvalid && bready;
		if (ar_f) begin
			ar_count++;
			rd_addr = araddr;
			rd_left = int'(arlen);
			last_arlen = arlen;
			last_arsize = arsize;
			last_arburst = arburst;
		end
		if (aw_f) begin
			aw_count++;
			last_awsize = awsize;
		end
		if (w_f) begin
			last_wstrb = wstrb;
			last_wlast = wlast;
			for (int k = 0; k < 4; k++)
				if (wstrb[k])
					mem[awaddr[11:2]][8*k +: 8] = wdata[8*k +: 8];
		end
		@(posedge clock);
		#1;
		if (reset) begin
			{arready, rvalid, rlast, awready, wready, bvalid} = '0;
			{rd_active, aw_done, w_done} = '0;
			{ar_wait, r_wait, wr_wait} = '0;
		end else begin
			// read side, one burst at a time
			if (ar_f) begin
				arready = 1'b0;
				rd_active = 1'b1;
				r_wait = next_delay();
			end else if (!rd_active) begin
				if (ar_wait > 0)
					ar_wait--;
				else
					arready = 1'b1;
			end
			if (rd_active && r_f) begin
				rvalid = 1'b0;
				if (rlast) begin
					rd_active = 1'b0;
					rlast = 1'b0;
					ar_wait = next_delay();
				end else begin
					rd_addr += 4;
					rd_left--;
					r_wait = next_delay();
				end
			end
			if (rd_active && !rvalid) begin
				if (r_wait > 0) begin
					r_wait--;
				end else begin
					rvalid = 1'b1;
					rdata = mem[rd_addr[11:2]];
					rlast = (rd_left == 0);
				end
			end
			// write side
			if (aw_f) begin
				awready = 1'b0;
				aw_done = 1'b1;
			end
			if (w_f) begin
				wready = 1'b0;
				w_done = 1'b1;
			end
			if (b_f) begin
				bvalid = 1'b0;
				{aw_done, w_done} = 2'b00;
				wr_wait = next_delay();
			end else if (aw_done && w_done) begin
				bvalid = 1'b1;
			end else if (!aw_done && !w_done && !bvalid) begin
				if (wr_wait > 0)
					wr_wait--;
				else
					{awready, wready} = 2'b11;
			end
		end
	end

	// ----------------------------------------
	// reference rules
	// ----------------------------------------
	function automatic strb_t lane_strb(funct3_t f3, logic [1:0] off);
		strb_t s;
		int lo, n;
		s = '0;
		lo = int'(off);
		n = (f3 == F3_SB) ? 1 : (f3 == F3_SH) ? 2 : 4;
		for (int k = 0; k < 4; k++)
			if (k >= lo && k < lo + n)
				s[k] = 1'b1;
		return s;
	endfunction

	// log2 of the bytes moved
	function automatic size_t access_size(funct3_t f3);
		case (f3)
			F3_LB, F3_LBU: return 3'd0;
			F3_LH, F3_LHU: return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	function automatic data_t load_ext(data_t word, logic [1:0] off, funct3_t f3);
		logic [7:0] b;
		logic [15:0] h;
		b = word[8*off +: 8];
		h = word[8*off[1] * 2 +: 16];
		case (f3)
			F3_LB: return {{24{b[7]}}, b};
			F3_LBU: return {24'h0, b};
			F3_LH: return {{16{h[15]}}, h};
			F3_LHU: return {16'h0, h};
			default: return word;
		endcase
	endfunction

	task automatic add_row(port_t port, addr_t addr, funct3_t f3, data_t wdata, addr_t addr2);
		rows[n_rows] = '{port, addr, addr2, f3, wdata, 0, 0, 0, 0, 0, 0, 0};
		n_rows++;
	endtask

	task automatic fill_expected();
		data_t lanes;
		for (int i = 0; i < n_rows; i++) begin
			case (rows[i].port)
				FETCH: begin
					rows[i].exp_val = golden[rows[i].addr[11:2]];
					rows[i].exp_size = 3'd2;
					rows[i].exp_len = 8'd3;
				end
				LOAD: begin
					rows[i].exp_val = load_ext(golden[rows[i].addr[11:2]],
						rows[i].addr[1:0], rows[i].f3);
					rows[i].exp_size = access_size(rows[i].f3);
					rows[i].exp_len = 8'd0;
				end
				STORE: begin
					if ((rows[i].addr & CLINT_SPAN_MASK) != CLINT_BASE) begin
						rows[i].aw_new = 1;
						rows[i].exp_strb = lane_strb(rows[i].f3, rows[i].addr[1:0]);
						rows[i].exp_size = access_size(rows[i].f3);
						lanes = rows[i].wdata << (8 * rows[i].addr[1:0]);
						for (int k = 0; k < 4; k++)
							if (rows[i].exp_strb[k])
								golden[rows[i].addr[11:2]][8*k +: 8] = lanes[8*k +: 8];
					end
				end
				BOTH: begin
					rows[i].exp_val = golden[rows[i].addr[11:2]];
					rows[i].exp_val2 = golden[rows[i].addr2[11:2]];
				end
				default: ;
			endcase
		end
	endtask

	// ----------------------------------------
	// port drivers
	// ----------------------------------------
	task automatic do_fetch(addr_t addr, output data_t got);
		fetch_addr = addr;
		fetch_req = 1'b1;
		do begin
			@(posedge clock);
			#1;
		end while (!fetch_ack);
		got = fetch_inst;
		fetch_req = 1'b0;
		do begin
			@(posedge clock);
			#1;
		end while (fetch_ack);
	endtask

	task automatic do_mem(logic we, funct3_t f3, addr_t addr, data_t wd, output data_t got);
		mem_we = we;
		mem_funct3 = f3;
		mem_addr = addr;
		mem_wdata = wd;
		mem_req = 1'b1;
		do begin
			@(posedge clock);
			#1;
		end while (!mem_ack);
		got = mem_rdata;
		mem_req = 1'b0;
		do begin
			@(posedge clock);
			#1;
		end while (mem_ack);
	endtask

	task automatic check(string name, data_t exp, data_t got, int i);
		assert (exp == got) else begin
			$display("[FAIL] row %0d %s expected %h got %h", i, name, exp, got);
			errors++;
		end
	endtask

	task automatic run_row(int i);
		data_t got, got2;
		int ar0, aw0, err0;
		ar0 = ar_count;
		aw0 = aw_count;
		err0 = errors;
		case (rows[i].port)
			FETCH: do_fetch(rows[i].addr, got);
			FENCE: begin
				repeat (2) @(posedge clock);
				#1 fence_i = 1'b1;
				@(posedge clock);
				#1 fence_i = 1'b0;
			end
			LOAD: do_mem(1'b0, rows[i].f3, rows[i].addr, '0, got);
			STORE: do_mem(1'b1, rows[i].f3, rows[i].addr, rows[i].wdata, got);
			TIMER: begin
				do_mem(1'b0, F3_LW, CLINT_BASE, '0, got);
				do_mem(1'b0, F3_LW, CLINT_BASE, '0, got2);
				assert (got2 > got) else begin
					$display("row %0d timer did not advance between two reads", i);
					errors++;
				end
			end
			BOTH: fork
				do_fetch(rows[i].addr, got);
				do_mem(1'b0, F3_LW, rows[i].addr2, '0, got2);
			join
		endcase
		if (rows[i].port inside {FETCH, BOTH})
			check("fetch_inst", rows[i].exp_val, got, i);
		if (rows[i].port == LOAD)
			check("mem_rdata", rows[i].exp_val, got, i);
		if (rows[i].port == BOTH)
			check("mem_rdata", rows[i].exp_val2, got2, i);
		if (rows[i].port inside {FETCH, BOTH})
			check("ar handshakes", rows[i].ar_new, ar_count - ar0, i);
		if (rows[i].port == LOAD || (rows[i].port == FETCH && rows[i].ar_new == 1)) begin
			check("arlen", data_t'(rows[i].exp_len), data_t'(last_arlen), i);
			check("arsize", data_t'(rows[i].exp_size), data_t'(last_arsize), i);
			check("arburst", 32'h1, data_t'(last_arburst), i);  // INCR
		end
		if (rows[i].port == STORE) begin
			check("aw handshakes", rows[i].aw_new, aw_count - aw0, i);
			if (rows[i].aw_new == 1) begin
				check("wstrb", data_t'(rows[i].exp_strb), data_t'(last_wstrb), i);
				check("awsize", data_t'(rows[i].exp_size), data_t'(last_awsize), i);
				check("wlast", 32'h1, data_t'(last_wlast), i);
			end
		end
		$display("row %0d %s addr %h %s", i, rows[i].port.name(), rows[i].addr,
			(errors == err0) ? "ok" : "bad");
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		clock = 1'b0;
		reset = 1'b1;
		{fetch_req, fence_i, mem_req, mem_we} = '0;
		fetch_addr = '0;
		mem_funct3 = '0;
		mem_addr = '0;
		mem_wdata = '0;
		{arready, rvalid, rlast, awready, wready, bvalid} = '0;
		rdata = '0;
		bresp = 2'b00;
		rresp = 2'b00;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = init_word(i);
			golden[i] = init_word(i);
		end

		add_row(FETCH, 32'h100, F3_LW, 0, 0);
		add_row(FETCH, 32'h108, F3_LW, 0, 0);
		add_row(FETCH, 32'h10C, F3_LW, 0, 0);
		add_row(FENCE, 32'h0, F3_LW, 0, 0);
		add_row(FETCH, 32'h104, F3_LW, 0, 0);
		add_row(FETCH, 32'h100, F3_LW, 0, 0);
		for (int k = 0; k < 4; k++) begin
			add_row(LOAD, 32'h200 + k, F3_LB, 0, 0);
			add_row(LOAD, 32'h204 + k, F3_LBU, 0, 0);
		end
		for (int k = 0; k < 4; k += 2) begin
			add_row(LOAD, 32'h208 + k, F3_LH, 0, 0);
			add_row(LOAD, 32'h20C + k, F3_LHU, 0, 0);
		end
		add_row(LOAD, 32'h210, F3_LW, 0, 0);
		add_row(STORE, 32'h301, F3_SB, 32'h1234_56A5, 0);
		add_row(STORE, 32'h302, F3_SH, 32'hCAFE_BEEF, 0);
		add_row(LOAD, 32'h300, F3_LW, 0, 0);
		add_row(STORE, 32'h304, F3_SW, 32'h1234_5678, 0);
		add_row(LOAD, 32'h304, F3_LW, 0, 0);
		add_row(STORE, 32'h30B, F3_SB, 32'h0000_007F, 0);
		add_row(LOAD, 32'h30B, F3_LB, 0, 0);
		add_row(LOAD, 32'h308, F3_LW, 0, 0);
		add_row(TIMER, CLINT_BASE, F3_LW, 0, 0);
		add_row(STORE, CLINT_BASE, F3_SW, 32'hDEAD_BEEF, 0);
		add_row(BOTH, 32'h180, F3_LW, 0, 32'h3F0);
		fill_expected();
		// miss rows cost one burst each, contention two reads
		rows[0].ar_new = 1;
		rows[4].ar_new = 1;
		rows[n_rows-1].ar_new = 2;
		table_ready = 1'b1;

		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("tests %0d errors %0d", n_rows, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (n_rows * 200) @(posedge clock);
		$display("run stopped, a handshake never completed");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: filelist.f
mem_pkg.sv
icache.sv
lsu.sv
xbar.sv
clint.sv
mem_subsys.sv
mem_subsys_assert.sv
tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
